// File: Bender.yml
package:
  name: conv_1x1_layer

sources:
  - files:
      - rtl/conv_pkg.sv
      - rtl/weight_store.sv
      - rtl/pixel_loop.sv
      - rtl/pointwise_mac.sv
      - rtl/align_fifo.sv
      - rtl/conv_1x1_layer.sv
  - target: test
    files:
      - test/conv_1x1_tb.sv

// File: flist.f
rtl/conv_pkg.sv
rtl/weight_store.sv
rtl/pixel_loop.sv
rtl/pointwise_mac.sv
rtl/align_fifo.sv
rtl/conv_1x1_layer.sv
test/conv_1x1_tb.sv

// File: rtl/align_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module align_fifo (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             wr_en,
  input  wire conv_pkg::data_t  din,
  output conv_pkg::data_t       dout,
  output logic                  valid_out
);

  conv_pkg::data_t               mem [conv_pkg::FIFO_DEPTH];
  logic [conv_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [conv_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [conv_pkg::FIFO_PTR_W:0]   count;
  logic                          read_en;
  logic                          empty;
  logic                          full;
  logic                          do_wr;
  logic                          do_rd;

  assign empty = (count == '0);
  assign full  = (count == (conv_pkg::FIFO_PTR_W + 1)'(conv_pkg::FIFO_DEPTH));
  assign do_rd = read_en && !empty;
  assign do_wr = wr_en && (!full || do_rd);

  //////////////////////////////
  // Pointers and level
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == (conv_pkg::FIFO_PTR_W)'(conv_pkg::FIFO_DEPTH - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == (conv_pkg::FIFO_PTR_W)'(conv_pkg::FIFO_DEPTH - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sticky once the first pixel is fully present
  always_ff @(posedge clk) begin
    if (reset) begin
      read_en <= 1'b0;
    end else if (count >= (conv_pkg::FIFO_PTR_W + 1)'(conv_pkg::PRIME_COUNT)) begin
      read_en <= 1'b1;
    end
  end

  //////////////////////////////
  // Storage and output
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
    if (do_rd) begin
      dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= do_rd;
    end
  end

endmodule

`default_nettype wire

// File: rtl/conv_1x1_layer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_1x1_layer (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            valid_in,
  input  wire conv_pkg::data_t pxl_in,
  input  wire logic            valid_weight_in,
  input  wire conv_pkg::data_t weight_in,
  output conv_pkg::data_t      pxl_out,
  output logic                 valid_out
);

  conv_pkg::mac_op_t     op;
  logic                  op_valid;
  conv_pkg::weight_idx_t weight_idx;
  conv_pkg::data_t       weight;
  conv_pkg::data_t       result;
  logic                  result_valid;

  //////////////////////////////
  // Weights
  //////////////////////////////

  weight_store weight_store_i (
    .clk             (clk),
    .reset           (reset),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .weight_idx      (weight_idx),
    .weight          (weight)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Replays each pixel once per output channel
  pixel_loop pixel_loop_i (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_in),
    .pxl_in     (pxl_in),
    .op         (op),
    .op_valid   (op_valid),
    .weight_idx (weight_idx)
  );

  pointwise_mac pointwise_mac_i (
    .clk          (clk),
    .reset        (reset),
    .op           (op),
    .op_valid     (op_valid),
    .weight       (weight),
    .result       (result),
    .result_valid (result_valid)
  );

  // Holds results until a whole pixel is there
  align_fifo align_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (result_valid),
    .din       (result),
    .dout      (pxl_out),
    .valid_out (valid_out)
  );

endmodule

`default_nettype wire

// File: rtl/conv_pkg.sv
`default_nettype none

package conv_pkg;

  //////////////////////////////
  // Layer sizes
  //////////////////////////////

  localparam int DATA_WIDTH = 16;
  localparam int ACC_WIDTH  = 32;
  localparam int CH_IN      = 4;
  localparam int CH_OUT     = 3;
  localparam int WEIGHT_NUM = CH_IN * CH_OUT;

  // Alignment FIFO
  localparam int FIFO_DEPTH  = 8;
  localparam int PRIME_COUNT = CH_OUT;
  localparam int FIFO_PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // Index widths, at least one bit each
  localparam int CH_IN_W  = (CH_IN > 1) ? $clog2(CH_IN) : 1;
  localparam int CH_OUT_W = (CH_OUT > 1) ? $clog2(CH_OUT) : 1;
  localparam int WEIGHT_W = (WEIGHT_NUM > 1) ? $clog2(WEIGHT_NUM) : 1;

  //////////////////////////////
  // Data types
  //////////////////////////////

  typedef logic signed [DATA_WIDTH-1:0] data_t;
  typedef logic signed [ACC_WIDTH-1:0]  acc_t;

  typedef logic [CH_IN_W-1:0]  ch_in_idx_t;
  typedef logic [CH_OUT_W-1:0] ch_out_idx_t;
  typedef logic [WEIGHT_W-1:0] weight_idx_t;

  // Saturation limits of a result word
  localparam data_t DATA_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
  localparam data_t DATA_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

  // One replayed channel word on its way to the MAC
  typedef struct packed {
    data_t       data;
    ch_in_idx_t  ch_in;
    ch_out_idx_t ch_out;
    logic        first;
    logic        last;
  } mac_op_t;

  typedef enum logic {
    LOOP_IDLE,
    LOOP_REPLAY
  } loop_state_t;

endpackage

`default_nettype wire

// File: rtl/pixel_loop.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_loop (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             valid_in,
  input  wire conv_pkg::data_t  pxl_in,
  output conv_pkg::mac_op_t     op,
  output logic                  op_valid,
  output conv_pkg::weight_idx_t weight_idx
);

  // Two banks, one filling while the other replays
  conv_pkg::data_t      bank_data [2][conv_pkg::CH_IN];
  logic [1:0]           bank_full;

  logic                 cap_bank;
  conv_pkg::ch_in_idx_t cap_ch;
  logic                 cap_done;

  conv_pkg::loop_state_t state;
  logic                  rep_bank;
  conv_pkg::ch_in_idx_t  in_ch;
  conv_pkg::ch_out_idx_t out_ch;
  logic                  in_last;
  logic                  out_last;
  logic                  rep_done;

  assign in_last  = (in_ch == conv_pkg::ch_in_idx_t'(conv_pkg::CH_IN - 1));
  assign out_last = (out_ch == conv_pkg::ch_out_idx_t'(conv_pkg::CH_OUT - 1));
  assign rep_done = (state == conv_pkg::LOOP_REPLAY) && in_last && out_last;
  assign cap_done = valid_in && (cap_ch == conv_pkg::ch_in_idx_t'(conv_pkg::CH_IN - 1));

  //////////////////////////////
  // Capture side
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (valid_in) begin
      bank_data[cap_bank][cap_ch] <= pxl_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cap_bank <= 1'b0;
      cap_ch   <= '0;
    end else if (valid_in) begin
      if (cap_done) begin
        cap_ch   <= '0;
        cap_bank <= ~cap_bank;
      end else begin
        cap_ch <= cap_ch + 1'b1;
      end
    end
  end

  // Freeing and filling never hit the same bank in one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      bank_full <= '0;
    end else begin
      if (rep_done) begin
        bank_full[rep_bank] <= 1'b0;
      end
      if (cap_done) begin
        bank_full[cap_bank] <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Replay FSM
  //////////////////////////////

  // Output channel outer loop, input channel inner loop
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= conv_pkg::LOOP_IDLE;
      rep_bank <= 1'b0;
      in_ch    <= '0;
      out_ch   <= '0;
    end else begin
      case (state)
        conv_pkg::LOOP_IDLE: begin
          in_ch  <= '0;
          out_ch <= '0;
          if (bank_full[rep_bank]) begin
            state <= conv_pkg::LOOP_REPLAY;
          end
        end
        conv_pkg::LOOP_REPLAY: begin
          if (!in_last) begin
            in_ch <= in_ch + 1'b1;
          end else begin
            in_ch <= '0;
            if (!out_last) begin
              out_ch <= out_ch + 1'b1;
            end else begin
              out_ch   <= '0;
              rep_bank <= ~rep_bank;
              // Back to back when the next pixel is already waiting
              if (!bank_full[~rep_bank]) begin
                state <= conv_pkg::LOOP_IDLE;
              end
            end
          end
        end
        default: state <= conv_pkg::LOOP_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Op and weight index
  //////////////////////////////

  assign op_valid  = (state == conv_pkg::LOOP_REPLAY);
  assign op.data   = bank_data[rep_bank][in_ch];
  assign op.ch_in  = in_ch;
  assign op.ch_out = out_ch;
  assign op.first  = (in_ch == '0);
  assign op.last   = in_last;

  assign weight_idx = conv_pkg::weight_idx_t'(out_ch) *
                      conv_pkg::weight_idx_t'(conv_pkg::CH_IN) +
                      conv_pkg::weight_idx_t'(in_ch);

endmodule

`default_nettype wire

// File: rtl/pointwise_mac.sv
`timescale 1ns/1ps
`default_nettype none

module pointwise_mac (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire conv_pkg::mac_op_t op,
  input  wire logic              op_valid,
  input  wire conv_pkg::data_t   weight,
  output conv_pkg::data_t        result,
  output logic                   result_valid
);

  // Product stage
  conv_pkg::acc_t prod_q;
  logic           prod_valid;
  logic           prod_first;
  logic           prod_last;

  // Accumulate stage
  conv_pkg::acc_t acc_q;
  conv_pkg::acc_t acc_next;
  conv_pkg::data_t acc_sat;

  //////////////////////////////
  // Stage one, multiply
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= op_valid;
    end
  end

  // Sign extension happens through the acc_t casts
  always_ff @(posedge clk) begin
    prod_q     <= conv_pkg::acc_t'(op.data) * conv_pkg::acc_t'(weight);
    prod_first <= op.first;
    prod_last  <= op.last;
  end

  //////////////////////////////
  // Stage two, accumulate
  //////////////////////////////

  // First input channel restarts the sum
  assign acc_next = prod_first ? prod_q : acc_q + prod_q;

  always_comb begin
    if (acc_next > conv_pkg::acc_t'(conv_pkg::DATA_MAX)) begin
      acc_sat = conv_pkg::DATA_MAX;
    end else if (acc_next < conv_pkg::acc_t'(conv_pkg::DATA_MIN)) begin
      acc_sat = conv_pkg::DATA_MIN;
    end else begin
      acc_sat = conv_pkg::data_t'(acc_next);
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      acc_q <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid && prod_last) begin
      result <= acc_sat;
    end
  end

  // One pulse per output channel
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= prod_valid && prod_last;
    end
  end

endmodule

`default_nettype wire

// File: rtl/weight_store.sv
`timescale 1ns/1ps
`default_nettype none

module weight_store (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  valid_weight_in,
  input  wire conv_pkg::data_t       weight_in,
  input  wire conv_pkg::weight_idx_t weight_idx,
  output conv_pkg::data_t            weight
);

  // Weights kept in output-major order
  conv_pkg::data_t       weight_mem [conv_pkg::WEIGHT_NUM];
  conv_pkg::weight_idx_t wr_ptr;

  //////////////////////////////
  // Load pointer
  //////////////////////////////

  // Wraps after a full set so a new set overwrites the old one
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (valid_weight_in) begin
      if (wr_ptr == conv_pkg::weight_idx_t'(conv_pkg::WEIGHT_NUM - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_weight_in) begin
      weight_mem[wr_ptr] <= weight_in;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Combinational so the weight lines up with the op in the same cycle
  assign weight = weight_mem[weight_idx];

endmodule

`default_nettype wire

// File: test/conv_1x1_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_1x1_tb;

  localparam int NUM_ROWS = 5;
  localparam int MAX_PIX  = 4;
  localparam int W_IDENT  = 0;
  localparam int W_RAND   = 1;
  localparam int W_LARGE  = 2;

  // One row of the stimulus table
  typedef struct packed {
    logic       load;
    logic [1:0] wset;
    logic       rand_pix;
    logic [7:0] num_pix;
    logic [7:0] gap;
    logic [7:0] spacing;
  } row_t;

  logic            clk;
  logic            reset;
  logic            valid_in;
  conv_pkg::data_t pxl_in;
  logic            valid_weight_in;
  conv_pkg::data_t weight_in;
  conv_pkg::data_t pxl_out;
  logic            valid_out;

  row_t            rows [NUM_ROWS];
  string           row_name [NUM_ROWS];
  conv_pkg::data_t pix_tab [NUM_ROWS][MAX_PIX][conv_pkg::CH_IN];
  conv_pkg::data_t w_model [conv_pkg::WEIGHT_NUM];
  conv_pkg::data_t out_q [$];

  int   err_count;
  int   cycles;
  int   cycle_limit;
  int   first_strobes;
  int   first_wait;
  logic first_done;

  conv_1x1_layer dut_i (
    .clk             (clk),
    .reset           (reset),
    .valid_in        (valid_in),
    .pxl_in          (pxl_in),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .pxl_out         (pxl_out),
    .valid_out       (valid_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Monitor and timeout
  //////////////////////////////

  // Outputs are registered, so the falling edge sees settled values
  always @(negedge clk) begin
    if (valid_out && reset) begin
      $display("valid_out was high during reset");
      err_count++;
    end else if (valid_out && !first_done) begin
      $display("valid_out was high before the first pixel was complete");
      err_count++;
    end
    if (valid_out && !reset) begin
      out_q.push_back(pxl_out);
    end
  end

  // Last result of the first pixel exists WEIGHT_NUM + 2 cycles after its last word
  always @(posedge clk) begin
    if (first_strobes == conv_pkg::CH_IN) begin
      first_wait++;
      if (first_wait >= conv_pkg::WEIGHT_NUM + 2) begin
        first_done = 1'b1;
      end
    end else if (valid_in && !reset) begin
      first_strobes++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles without all results", cycles);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Table and reference model
  //////////////////////////////

  task automatic set_pixel(input int r, input int p, input int a, input int b,
                           input int c, input int d);
    pix_tab[r][p][0] = conv_pkg::data_t'(a);
    pix_tab[r][p][1] = conv_pkg::data_t'(b);
    pix_tab[r][p][2] = conv_pkg::data_t'(c);
    pix_tab[r][p][3] = conv_pkg::data_t'(d);
  endtask

  task automatic fill_table();
    row_name[0] = "identity";
    rows[0]     = '{1'b1, 2'(W_IDENT), 1'b0, 8'd2, 8'd0, 8'(conv_pkg::WEIGHT_NUM)};
    row_name[1] = "random_min_spacing";
    rows[1]     = '{1'b1, 2'(W_RAND), 1'b1, 8'd4, 8'd0, 8'(conv_pkg::WEIGHT_NUM)};
    row_name[2] = "saturation";
    rows[2]     = '{1'b1, 2'(W_LARGE), 1'b0, 8'd3, 8'd0, 8'(conv_pkg::WEIGHT_NUM + 3)};
    row_name[3] = "weight_reload";
    rows[3]     = '{1'b1, 2'(W_RAND), 1'b1, 8'd3, 8'd0, 8'(conv_pkg::WEIGHT_NUM)};
    row_name[4] = "gapped_strobes";
    rows[4]     = '{1'b0, 2'(W_RAND), 1'b1, 8'd3, 8'd3, 8'(conv_pkg::WEIGHT_NUM)};
    set_pixel(0, 0, 5, -7, 300, 12);
    set_pixel(0, 1, -1000, 42, 0, 9);
    // Sums well past the data range in both directions
    set_pixel(2, 0, 20000, 20000, 20000, 20000);
    set_pixel(2, 1, -20000, -20000, -20000, -20000);
    set_pixel(2, 2, 1, 0, 0, 0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int p = 0; p < MAX_PIX; p++) begin
        for (int c = 0; c < conv_pkg::CH_IN; c++) begin
          if (rows[r].rand_pix) begin
            pix_tab[r][p][c] = conv_pkg::data_t'(int'($urandom_range(255)) - 128);
          end
        end
      end
    end
  endtask

  function automatic int cycle_budget();
    int total;
    total = 8 + 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += int'(rows[r].num_pix) *
               (conv_pkg::CH_IN * (int'(rows[r].gap) + 1) + int'(rows[r].spacing));
      if (rows[r].load) begin
        total += conv_pkg::WEIGHT_NUM + 1;
      end
    end
    return total;
  endfunction

  // Sum of pixel times weight over the input channels, clipped to data_t
  function automatic conv_pkg::data_t ref_output(input int r, input int p, input int o);
    conv_pkg::acc_t sum;
    sum = '0;
    for (int i = 0; i < conv_pkg::CH_IN; i++) begin
      sum += conv_pkg::acc_t'(pix_tab[r][p][i]) *
             conv_pkg::acc_t'(w_model[o * conv_pkg::CH_IN + i]);
    end
    if (sum > 32'sd32767) begin
      return conv_pkg::data_t'(16'sh7fff);
    end else if (sum < -32'sd32768) begin
      return conv_pkg::data_t'(16'sh8000);
    end
    return conv_pkg::data_t'(sum);
  endfunction

  //////////////////////////////
  // Drivers and checks
  //////////////////////////////

  task automatic load_weights(input int kind);
    int o;
    int i;
    for (int k = 0; k < conv_pkg::WEIGHT_NUM; k++) begin
      o = k / conv_pkg::CH_IN;
      i = k % conv_pkg::CH_IN;
      case (kind)
        W_IDENT: w_model[k] = (o == i) ? conv_pkg::data_t'(1) : conv_pkg::data_t'(0);
        W_LARGE: w_model[k] = (o == 0) ? conv_pkg::data_t'(20000) :
                              (o == 1) ? conv_pkg::data_t'(-20000) : conv_pkg::data_t'(1);
        default: w_model[k] = conv_pkg::data_t'(int'($urandom_range(511)) - 256);
      endcase
      @(negedge clk);
      valid_weight_in = 1'b1;
      weight_in       = w_model[k];
    end
    @(negedge clk);
    valid_weight_in = 1'b0;
  endtask

  // Strobes one pixel, then idles until the next pixel may start
  task automatic send_pixel(input int r, input int p);
    int used;
    used = 0;
    for (int c = 0; c < conv_pkg::CH_IN; c++) begin
      @(negedge clk);
      valid_in = 1'b1;
      pxl_in   = pix_tab[r][p][c];
      used++;
      repeat (int'(rows[r].gap)) begin
        @(negedge clk);
        valid_in = 1'b0;
        used++;
      end
    end
    @(negedge clk);
    valid_in = 1'b0;
    used++;
    while (used < int'(rows[r].spacing)) begin
      @(negedge clk);
      used++;
    end
  endtask

  task automatic check_data(input string name, input int idx,
                            input conv_pkg::data_t exp, input conv_pkg::data_t act);
    if (act !== exp) begin
      $display("mismatch in %s: result %0d expected %0d actual %0d", name, idx, exp, act);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("mismatch in %s: output count expected %0d actual %0d", name, exp, act);
      err_count++;
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int n;
    int idx;
    int errs_before;
    int rows_ok;
    int rows_bad;
    void'($urandom(32'hecd8));
    reset           = 1'b1;
    valid_in        = 1'b0;
    pxl_in          = '0;
    valid_weight_in = 1'b0;
    weight_in       = '0;
    err_count       = 0;
    cycles          = 0;
    cycle_limit     = 0;
    first_strobes   = 0;
    first_wait      = 0;
    first_done      = 1'b0;
    rows_ok         = 0;
    rows_bad        = 0;
    fill_table();
    cycle_limit = cycle_budget();
    repeat (8) @(negedge clk);
    reset = 1'b0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      errs_before = err_count;
      if (rows[r].load) begin
        load_weights(int'(rows[r].wset));
      end
      for (int p = 0; p < int'(rows[r].num_pix); p++) begin
        send_pixel(r, p);
      end
      n = int'(rows[r].num_pix) * conv_pkg::CH_OUT;
      while (out_q.size() < n) begin
        @(negedge clk);
      end
      // Short quiet spell to catch any surplus output
      repeat (4) @(negedge clk);
      check_count(row_name[r], n, out_q.size());
      idx = 0;
      for (int p = 0; p < int'(rows[r].num_pix); p++) begin
        for (int o = 0; o < conv_pkg::CH_OUT; o++) begin
          if (idx < out_q.size()) begin
            check_data(row_name[r], idx, ref_output(r, p, o), out_q[idx]);
          end
          idx++;
        end
      end
      out_q.delete();
      if (err_count == errs_before) begin
        rows_ok++;
        $display("%s: ok, %0d results", row_name[r], n);
      end else begin
        rows_bad++;
        $display("%s: %0d errors", row_name[r], err_count - errs_before);
      end
    end

    $display("rows ok %0d, rows with errors %0d, total errors %0d",
             rows_ok, rows_bad, err_count);
    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
